// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - src/mipsPkg.sv
  - src/decodeIf.sv
  - src/instructionDecoder.sv
  - src/cpuControl.sv
  - src/programCounter.sv
  - src/registerFile.sv
  - src/alu.sv
  - src/memoryAccess.sv
  - src/mipsCpuBus.sv
  - target: test
    files:
      - tests/avalonMemory.sv
      - tests/mipsCpuBusTb.sv

// File: mipsCpuBus.f
src/mipsPkg.sv
src/decodeIf.sv
src/instructionDecoder.sv
src/cpuControl.sv
src/programCounter.sv
src/registerFile.sv
src/alu.sv
src/memoryAccess.sv
src/mipsCpuBus.sv
tests/avalonMemory.sv
tests/mipsCpuBusTb.sv

// File: src/alu.sv
// Combinational ALU for arithmetic, logic, shifts, compares and the BEQ/BNE condition
module alu (
    decodeIf.consumer                     dec,
    input  logic [mipsPkg::DataWidth-1:0] rsValue,
    input  logic [mipsPkg::DataWidth-1:0] rtValue,
    output logic [mipsPkg::DataWidth-1:0] result,
    output logic                          branchTaken
);
    import mipsPkg::*;

    logic                 zeroExtend;
    logic [DataWidth-1:0] extImmediate;
    logic [DataWidth-1:0] operandB;

    // ANDI, ORI and XORI take the immediate unsigned
    assign zeroExtend = (dec.aluOp == ALU_AND) || (dec.aluOp == ALU_OR)
        || (dec.aluOp == ALU_XOR);
    assign extImmediate = zeroExtend ? {{(DataWidth-16){1'b0}}, dec.immediate}
                                     : {{(DataWidth-16){dec.immediate[15]}}, dec.immediate};
    assign operandB = dec.useImmediate ? extImmediate : rtValue;

    always_comb begin
        case (dec.aluOp)
            ALU_ADD:  result = rsValue + operandB;
            ALU_SUB:  result = rsValue - operandB;
            ALU_AND:  result = rsValue & operandB;
            ALU_OR:   result = rsValue | operandB;
            ALU_XOR:  result = rsValue ^ operandB;
            ALU_SLT:  result = {{(DataWidth-1){1'b0}}, $signed(rsValue) < $signed(operandB)};
            ALU_SLTU: result = {{(DataWidth-1){1'b0}}, rsValue < operandB};
            ALU_SLL:  result = rtValue << dec.shamt;   // Shifts act on rt
            ALU_SRL:  result = rtValue >> dec.shamt;
            ALU_SRA:  result = $unsigned($signed(rtValue) >>> dec.shamt);
            ALU_LUI:  result = {dec.immediate, 16'b0};
            default:  result = '0;
        endcase
    end

    // Compare raw registers for branches
    assign branchTaken = (dec.isBranchEq && (rsValue == rtValue))
        || (dec.isBranchNe && (rsValue != rtValue));
endmodule

// File: src/cpuControl.sv
// Fetch, execute, memory and halt FSM that raises the bus, register and PC strobes
module cpuControl (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  logic     pcIsZero,
    decodeIf.consumer dec,
    output logic     fetchRead,
    output logic     memRead,
    output logic     memWrite,
    output logic     regWrite,
    output logic     pcAdvance,
    output logic     fetchAccept,
    output logic     memLatch,
    output logic     active
);
    import mipsPkg::*;

    state_t state;
    state_t nextState;
    logic   started;     // Low for the reset cycles so no read leaks out
    logic   memOp;

    assign memOp = dec.isLoad || dec.isStore;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            started <= 1'b0;
            active <= 1'b1;
        end else begin
            state <= nextState;
            started <= 1'b1;
            if (state == HALT) begin
                active <= 1'b0;   // One cycle after entering HALT
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (started && pcIsZero) begin
                    nextState = HALT;   // Jump to zero ends the program
                end else if (fetchAccept) begin
                    nextState = EXEC;
                end
            end
            EXEC:    nextState = memOp ? MEMORY : FETCH;
            MEMORY:  nextState = waitrequest ? MEMORY : FETCH;
            default: nextState = HALT;  // Only reset leaves
        endcase
    end

    // Bus strobes
    assign fetchRead = (state == FETCH) && started && !pcIsZero;
    assign fetchAccept = fetchRead && !waitrequest;
    assign memRead = (state == MEMORY) && dec.isLoad;
    assign memWrite = (state == MEMORY) && dec.isStore;
    assign memLatch = (state == EXEC) && memOp;   // Capture address and store data

    // ALU results at end of EXEC and load data on the accepted read
    assign regWrite = dec.writesReg
        && (((state == EXEC) && !dec.isLoad) || (memRead && !waitrequest));
    assign pcAdvance = ((state == EXEC) && !memOp) || ((state == MEMORY) && !waitrequest);

    noBusOverlap: assert property (@(posedge clk) disable iff (reset)
        !((fetchRead || memRead) && memWrite));

    haltIsFinal: assert property (@(posedge clk) disable iff (reset)
        (state == HALT) |=> (state == HALT));
endmodule

// File: src/decodeIf.sv
// Decoded instruction fields, driven by the decoder and read by control, PC, ALU, registers and bus
interface decodeIf;
    import mipsPkg::*;

    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] destReg;    // rd or rt depending on format
    logic [4:0]              shamt;
    logic [15:0]             immediate;
    logic [25:0]             target;
    aluOp_t                  aluOp;
    logic                    useImmediate; // Operand B from immediate
    logic                    isLoad;
    logic                    isStore;
    logic                    isBranchEq;
    logic                    isBranchNe;
    logic                    isJump;
    logic                    isJumpReg;
    logic                    writesReg;    // Never set for register 0

    modport decoder (output rs, rt, destReg, shamt, immediate, target, aluOp, useImmediate,
                     isLoad, isStore, isBranchEq, isBranchNe, isJump, isJumpReg, writesReg);
    modport consumer (input rs, rt, destReg, shamt, immediate, target, aluOp, useImmediate,
                      isLoad, isStore, isBranchEq, isBranchNe, isJump, isJumpReg, writesReg);
endinterface

// File: src/instructionDecoder.sv
// Instruction register and field decode, loaded on an accepted fetch and held through execution
module instructionDecoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [mipsPkg::DataWidth-1:0] readdata,
    input  logic                          fetchAccept,
    decodeIf.decoder                      dec
);
    import mipsPkg::*;

    instruction_t instrReg;
    logic         resultWrite;   // Instruction produces a register result

    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;   // SLL r0 so decode stays a no-op
        end else if (fetchAccept) begin
            instrReg <= readdata;
        end
    end

    // Raw fields straight from the union views
    assign dec.rs = instrReg.r.rs;
    assign dec.rt = instrReg.r.rt;
    assign dec.shamt = instrReg.r.shamt;
    assign dec.immediate = instrReg.i.immediate;
    assign dec.target = instrReg.j.target;
    assign dec.useImmediate = (instrReg.r.opcode != OP_SPECIAL);
    assign dec.writesReg = resultWrite && (dec.destReg != '0);

    always_comb begin
        dec.aluOp = ALU_ADD;          // Also address add for LW/SW
        dec.destReg = instrReg.i.rt;  // I-type target
        dec.isLoad = 1'b0;
        dec.isStore = 1'b0;
        dec.isBranchEq = 1'b0;
        dec.isBranchNe = 1'b0;
        dec.isJump = 1'b0;
        dec.isJumpReg = 1'b0;
        resultWrite = 1'b1;
        case (instrReg.r.opcode)
            OP_SPECIAL: begin
                dec.destReg = instrReg.r.rd;
                case (instrReg.r.funct)
                    FN_ADDU: dec.aluOp = ALU_ADD;
                    FN_SUBU: dec.aluOp = ALU_SUB;
                    FN_AND:  dec.aluOp = ALU_AND;
                    FN_OR:   dec.aluOp = ALU_OR;
                    FN_XOR:  dec.aluOp = ALU_XOR;
                    FN_SLT:  dec.aluOp = ALU_SLT;
                    FN_SLTU: dec.aluOp = ALU_SLTU;
                    FN_SLL:  dec.aluOp = ALU_SLL;
                    FN_SRL:  dec.aluOp = ALU_SRL;
                    FN_SRA:  dec.aluOp = ALU_SRA;
                    FN_JR: begin
                        dec.isJumpReg = 1'b1;
                        resultWrite = 1'b0;
                    end
                    default: resultWrite = 1'b0;  // Unknown funct acts as no-op
                endcase
            end
            OP_ADDIU: dec.aluOp = ALU_ADD;
            OP_SLTI:  dec.aluOp = ALU_SLT;
            OP_SLTIU: dec.aluOp = ALU_SLTU;
            OP_ANDI:  dec.aluOp = ALU_AND;
            OP_ORI:   dec.aluOp = ALU_OR;
            OP_XORI:  dec.aluOp = ALU_XOR;
            OP_LUI:   dec.aluOp = ALU_LUI;
            OP_LW:    dec.isLoad = 1'b1;
            OP_SW: begin
                dec.isStore = 1'b1;
                resultWrite = 1'b0;
            end
            OP_BEQ: begin
                dec.isBranchEq = 1'b1;
                resultWrite = 1'b0;
            end
            OP_BNE: begin
                dec.isBranchNe = 1'b1;
                resultWrite = 1'b0;
            end
            OP_J: begin
                dec.isJump = 1'b1;
                resultWrite = 1'b0;
            end
            default: resultWrite = 1'b0;  // Unknown opcode
        endcase
    end
endmodule

// File: src/memoryAccess.sv
// Avalon master side with address mux, data address and store registers and write-back select
module memoryAccess (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mipsPkg::DataWidth-1:0]     pc,
    input  logic [mipsPkg::DataWidth-1:0]     aluResult,
    input  logic [mipsPkg::DataWidth-1:0]     rtValue,
    input  logic [mipsPkg::DataWidth-1:0]     readdata,
    input  logic                              memLatch,
    input  logic                              fetchRead,
    input  logic                              memRead,
    input  logic                              memWrite,
    decodeIf.consumer                         dec,
    output logic [mipsPkg::DataWidth-1:0]     address,
    output logic                              read,
    output logic                              write,
    output logic [mipsPkg::DataWidth-1:0]     writedata,
    output logic [mipsPkg::DataWidth/8-1:0]   byteenable,
    output logic [mipsPkg::DataWidth-1:0]     writeBack
);
    import mipsPkg::*;

    logic [DataWidth-1:0] dataAddress;

    always_ff @(posedge clk) begin
        if (reset) begin
            dataAddress <= '0;
            writedata <= '0;
        end else if (memLatch) begin
            dataAddress <= aluResult;  // rs + sign-extended offset
            writedata <= rtValue;
        end
    end

    assign address = fetchRead ? pc : dataAddress;
    assign read = fetchRead || memRead;
    assign write = memWrite;
    assign byteenable = '1;   // Word accesses only
    assign writeBack = dec.isLoad ? readdata : aluResult;

    // Back-to-back request cycles only happen under waitrequest
    requestHeld: assert property (@(posedge clk) disable iff (reset)
        ((fetchRead ##1 fetchRead) or ((memRead || memWrite) ##1 (memRead || memWrite)))
        |-> ($stable(address) && $stable(writedata)));
endmodule

// File: src/mipsCpuBus.sv
// Top level of the multicycle MIPS CPU, wiring the core blocks to one Avalon master port
module mipsCpuBus (
    input  logic                              clk,
    input  logic                              reset,
    output logic                              active,
    output logic [mipsPkg::DataWidth-1:0]     registerV0,
    output logic [mipsPkg::DataWidth-1:0]     address,
    output logic                              write,
    output logic                              read,
    input  logic                              waitrequest,
    output logic [mipsPkg::DataWidth-1:0]     writedata,
    output logic [mipsPkg::DataWidth/8-1:0]   byteenable,
    input  logic [mipsPkg::DataWidth-1:0]     readdata
);
    import mipsPkg::*;

    // Control strobes
    logic fetchRead;
    logic fetchAccept;
    logic memRead;
    logic memWrite;
    logic memLatch;
    logic regWrite;
    logic pcAdvance;
    logic pcIsZero;
    logic branchTaken;

    // Datapath
    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] rsValue;
    logic [DataWidth-1:0] rtValue;
    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] writeBack;

    decodeIf dec ();

    instructionDecoder decoder0 (.clk(clk), .reset(reset), .readdata(readdata),
        .fetchAccept(fetchAccept), .dec(dec));

    cpuControl control0 (.clk(clk), .reset(reset), .waitrequest(waitrequest),
        .pcIsZero(pcIsZero), .dec(dec), .fetchRead(fetchRead), .memRead(memRead),
        .memWrite(memWrite), .regWrite(regWrite), .pcAdvance(pcAdvance),
        .fetchAccept(fetchAccept), .memLatch(memLatch), .active(active));

    programCounter pc0 (.clk(clk), .reset(reset), .pcAdvance(pcAdvance),
        .branchTaken(branchTaken), .rsValue(rsValue), .dec(dec), .pc(pc),
        .pcIsZero(pcIsZero));

    registerFile regs0 (.clk(clk), .reset(reset), .dec(dec), .regWrite(regWrite),
        .writeData(writeBack), .rsValue(rsValue), .rtValue(rtValue),
        .registerV0(registerV0));

    alu alu0 (.dec(dec), .rsValue(rsValue), .rtValue(rtValue), .result(aluResult),
        .branchTaken(branchTaken));

    memoryAccess mem0 (.clk(clk), .reset(reset), .pc(pc), .aluResult(aluResult),
        .rtValue(rtValue), .readdata(readdata), .memLatch(memLatch),
        .fetchRead(fetchRead), .memRead(memRead), .memWrite(memWrite), .dec(dec),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .writeBack(writeBack));
endmodule

// File: src/mipsPkg.sv
// Shared widths, encodings, FSM states and the instruction word layout for the MIPS bus CPU
package mipsPkg;

    localparam int DataWidth = 32;                              // Data and address width
    localparam int RegAddrWidth = 5;                            // 32 general registers
    localparam logic [DataWidth-1:0] ResetVector = 32'hBFC00000; // First fetch address

    // Major opcodes of the kept subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,  // R-type decoded by funct
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [1:0] {FETCH, EXEC, MEMORY, HALT} state_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOp_t;

    // One fetched word in three encodings
    typedef union packed {
        struct packed {
            opcode_t                 opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            funct_t                  funct;
        } r;
        struct packed {
            opcode_t                 opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [15:0]             immediate;
        } i;
        struct packed {
            opcode_t     opcode;
            logic [25:0] target;   // Word index within the current 256 MB region
        } j;
    } instruction_t;

endpackage

// File: src/programCounter.sv
// Program counter with sequential, branch, jump and jump-register updates plus halt detection
module programCounter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pcAdvance,
    input  logic                          branchTaken,
    input  logic [mipsPkg::DataWidth-1:0] rsValue,
    decodeIf.consumer                     dec,
    output logic [mipsPkg::DataWidth-1:0] pc,
    output logic                          pcIsZero
);
    import mipsPkg::*;

    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpTarget;

    assign pcPlus4 = pc + DataWidth'(4);
    assign branchTarget = pcPlus4 + {{(DataWidth-18){dec.immediate[15]}}, dec.immediate, 2'b00};
    assign jumpTarget = {pcPlus4[DataWidth-1:28], dec.target, 2'b00};  // Same 256 MB region
    assign pcIsZero = (pc == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= ResetVector;
        end else if (pcAdvance) begin
            if (dec.isJumpReg) begin
                pc <= rsValue;
            end else if (dec.isJump) begin
                pc <= jumpTarget;
            end else if (branchTaken) begin
                pc <= branchTarget;
            end else begin
                pc <= pcPlus4;   // Also the step after LW/SW
            end
        end
    end
endmodule

// File: src/registerFile.sv
// General register file with two combinational read ports, one write port and a v0 tap
module registerFile (
    input  logic                          clk,
    input  logic                          reset,
    decodeIf.consumer                     dec,
    input  logic                          regWrite,
    input  logic [mipsPkg::DataWidth-1:0] writeData,
    output logic [mipsPkg::DataWidth-1:0] rsValue,
    output logic [mipsPkg::DataWidth-1:0] rtValue,
    output logic [mipsPkg::DataWidth-1:0] registerV0
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [2**RegAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (dec.destReg != '0)) begin   // r0 is hardwired
            regs[dec.destReg] <= writeData;
        end
    end

    assign rsValue = regs[dec.rs];
    assign rtValue = regs[dec.rt];
    assign registerV0 = regs[2];   // $v0

    zeroRegister: assert property (@(posedge clk) disable iff (reset)
        (dec.rs == '0) |-> (rsValue == '0));
endmodule

// File: tests/avalonMemory.sv
// Avalon slave model for the testbench, sparse word storage with random wait states per request
module avalonMemory (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mipsPkg::DataWidth-1:0]   address,
    input  logic                            read,
    input  logic                            write,
    input  logic [mipsPkg::DataWidth-1:0]   writedata,
    input  logic [mipsPkg::DataWidth/8-1:0] byteenable,
    output logic                            waitrequest,
    output logic [mipsPkg::DataWidth-1:0]   readdata
);
    import mipsPkg::*;

    logic [DataWidth-1:0] words [logic [DataWidth-1:0]];  // Keyed by byte address
    logic [31:0]          rngState;
    logic                 busy;       // Request seen but not yet accepted
    logic [1:0]           waitLeft;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Untouched words return a pattern of their own address
    function automatic logic [DataWidth-1:0] lookup(input logic [DataWidth-1:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return addr ^ 32'h5A3C96E1;
    endfunction

    initial begin
        rngState = 32'hf3a55975;
        busy = 1'b0;
        waitLeft = '0;
        waitrequest = 1'b0;
        readdata = '0;
    end

    // Transfer accepted in a cycle with waitrequest low
    always @(negedge clk) begin
        if (busy && (read || write) && !waitrequest) begin
            if (write && (byteenable == '1)) begin
                words[address] = writedata;
            end
            busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        #1;
        if (reset) begin
            busy = 1'b0;
            waitLeft = '0;
        end else if ((read || write) && !busy) begin
            rngState = xorshift(rngState);
            waitLeft = rngState[1:0];   // 0 to 3 wait cycles
            busy = 1'b1;
        end else if (busy && (waitLeft != 0)) begin
            waitLeft = waitLeft - 1'b1;
        end
        waitrequest = busy && (waitLeft != 0);
        readdata = (busy && read) ? lookup(address) : '0;
    end
endmodule

// File: tests/mipsCpuBusTb.sv
// Testbench for the MIPS bus CPU, runs a fixed program and checks bus, branch and halt behavior
module mipsCpuBusTb;
    import mipsPkg::*;

    localparam int TimeoutCycles = 2000;
    // Program constants
    localparam logic [15:0] ConstHi = 16'h1234;
    localparam logic [15:0] ConstLo = 16'h5678;
    localparam logic [15:0] ConstB = 16'hFFFD;      // -3
    localparam logic [15:0] BaseImm = 16'h0100;     // Data area
    localparam logic [15:0] StoreOffset = 16'h0004;
    localparam logic [15:0] SltiImm = 16'hFFFE;
    localparam logic [15:0] SltiuImm = 16'hFFFF;
    localparam logic [15:0] AndiImm = 16'hF0F0;
    localparam logic [15:0] XoriImm = 16'h8001;
    localparam logic [15:0] AddiuImm = 16'h8000;
    localparam logic [15:0] LoopCount = 16'd4;
    localparam logic [15:0] BneImm = 16'hFFFE;      // Back to the decrement
    localparam logic [15:0] PoisonImm = 16'hDEAD;
    localparam logic [4:0]  ShiftL = 5'd3;
    localparam logic [4:0]  ShiftRa = 5'd5;
    localparam logic [4:0]  ShiftRl = 5'd1;
    localparam int LoopIndex = 28;
    localparam int JrIndex = 33;

    logic                    clk;
    logic                    reset;
    logic                    active;
    logic [DataWidth-1:0]    registerV0;
    logic [DataWidth-1:0]    address;
    logic                    write;
    logic                    read;
    logic                    waitrequest;
    logic [DataWidth-1:0]    writedata;
    logic [DataWidth/8-1:0]  byteenable;
    logic [DataWidth-1:0]    readdata;

    int                      errors;
    int                      busErrors;
    int                      passed;
    int                      failed;
    int                      transfers;
    int                      storeCount;
    logic                    loadSeen;
    logic [DataWidth-1:0]    dataAddr;
    logic [DataWidth-1:0]    expectedV0;
    logic [25:0]             jumpField;
    logic [DataWidth-1:0]    storeAddress;
    logic [DataWidth-1:0]    storeData;
    logic [DataWidth/8-1:0]  storeEnable;
    logic [DataWidth-1:0]    fetchLog [$];
    logic [DataWidth-1:0]    expectedFetch [$];

    mipsCpuBus dut0 (.clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata));

    avalonMemory memory0 (.clk(clk), .reset(reset), .address(address), .read(read),
        .write(write), .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata));

    always #4 clk = ~clk;

    function automatic logic [31:0] signExtend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
            input logic [4:0] rd, input logic [4:0] shamt, input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encodeI(input opcode_t op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // r2 after the ALU chain by each instruction's rule
    function automatic logic [31:0] computeExpected();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        logic [31:0] v;
        a = {ConstHi, 16'h0} | {16'h0, ConstLo};
        b = signExtend(ConstB);
        base = signExtend(BaseImm);
        v = a + b;
        v = v - base;
        v = v & a;
        v = v | base;
        v = v ^ b;
        v = v << ShiftL;
        v = $unsigned($signed(v) >>> ShiftRa);
        v = v >> ShiftRl;
        v = v + 32'($signed(b) < $signed(a));                 // SLT
        v = v + 32'(b < a);                                   // SLTU
        v = v + 32'($signed(b) < $signed(signExtend(SltiImm)));
        v = v + 32'(base < signExtend(SltiuImm));             // Immediate still sign-extended
        v = v + (b & {16'h0, AndiImm});
        v = v ^ {16'h0, XoriImm};
        v = v + signExtend(AddiuImm);
        return v;
    endfunction

    task automatic place(input int index, input logic [31:0] word);
        memory0.words[ResetVector + 32'(index * 4)] = word;
    endtask

    task automatic loadProgram();
        place(0, encodeI(OP_LUI, 0, 8, ConstHi));
        place(1, encodeI(OP_ORI, 8, 8, ConstLo));
        place(2, encodeI(OP_ADDIU, 0, 9, ConstB));
        place(3, encodeI(OP_ADDIU, 0, 10, BaseImm));
        place(4, encodeR(8, 9, 2, 0, FN_ADDU));
        place(5, encodeR(2, 10, 2, 0, FN_SUBU));
        place(6, encodeR(2, 8, 2, 0, FN_AND));
        place(7, encodeR(2, 10, 2, 0, FN_OR));
        place(8, encodeR(2, 9, 2, 0, FN_XOR));
        place(9, encodeR(0, 2, 2, ShiftL, FN_SLL));
        place(10, encodeR(0, 2, 2, ShiftRa, FN_SRA));
        place(11, encodeR(0, 2, 2, ShiftRl, FN_SRL));
        place(12, encodeR(9, 8, 11, 0, FN_SLT));
        place(13, encodeR(9, 8, 12, 0, FN_SLTU));
        place(14, encodeR(2, 11, 2, 0, FN_ADDU));
        place(15, encodeR(2, 12, 2, 0, FN_ADDU));
        place(16, encodeI(OP_SLTI, 9, 11, SltiImm));
        place(17, encodeI(OP_SLTIU, 10, 12, SltiuImm));
        place(18, encodeR(2, 11, 2, 0, FN_ADDU));
        place(19, encodeR(2, 12, 2, 0, FN_ADDU));
        place(20, encodeI(OP_ANDI, 9, 11, AndiImm));
        place(21, encodeR(2, 11, 2, 0, FN_ADDU));
        place(22, encodeI(OP_XORI, 2, 2, XoriImm));
        place(23, encodeI(OP_ADDIU, 2, 2, AddiuImm));
        place(24, encodeI(OP_SW, 10, 2, StoreOffset));
        place(25, encodeI(OP_ADDIU, 0, 2, 16'h0));     // Clobber so LW must restore r2
        place(26, encodeI(OP_LW, 10, 2, StoreOffset));
        place(27, encodeI(OP_ADDIU, 0, 13, LoopCount));
        place(LoopIndex, encodeI(OP_ADDIU, 13, 13, 16'hFFFF));
        place(29, encodeI(OP_BNE, 13, 0, BneImm));
        place(30, encodeI(OP_BEQ, 13, 8, 16'h0001));    // Would land on the poison
        place(31, {OP_J, jumpField});
        place(32, encodeI(OP_ADDIU, 0, 2, PoisonImm));
        place(JrIndex, encodeR(0, 0, 0, 0, FN_JR));     // Jump to zero halts
        place(34, encodeI(OP_ADDIU, 0, 2, PoisonImm));
    endtask

    // Fetch order from the branch and jump rules
    task automatic buildExpectedFetches();
        logic [31:0] addr;
        logic [31:0] jumpNext;
        int          count;
        for (int i = 0; i < LoopIndex; i++) begin
            expectedFetch.push_back(ResetVector + 32'(i * 4));
        end
        addr = ResetVector + 32'(LoopIndex * 4);
        count = LoopCount;
        do begin
            expectedFetch.push_back(addr);       // Decrement
            expectedFetch.push_back(addr + 4);   // BNE
            count--;
            if (count != 0) begin
                addr = (addr + 4) + 4 + (signExtend(BneImm) << 2);
            end
        end while (count != 0);
        addr = addr + 8;                         // BEQ falls through
        expectedFetch.push_back(addr);
        expectedFetch.push_back(addr + 4);       // J
        jumpNext = addr + 8;
        expectedFetch.push_back({jumpNext[31:28], jumpField, 2'b00});
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            passed++;
            $display("Test %s: PASS", name);
        end else begin
            failed++;
            $display("Test %s: FAIL with %0d errors", name, errors - errorsBefore);
        end
    endtask

    task automatic giveUp(input string reason);
        $display("Timeout after %0d cycles waiting for %s", TimeoutCycles, reason);
        $display("Testbench failed");
        $finish;
    endtask

    // Accepted transfers sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && read && !waitrequest) begin
            transfers++;
            if (address == dataAddr) begin
                loadSeen = 1'b1;
            end else begin
                fetchLog.push_back(address);
            end
        end
        if (!reset && write && !waitrequest) begin
            transfers++;
            storeCount++;
            storeAddress = address;
            storeData = writedata;
            storeEnable = byteenable;
        end
    end

    readHeld: assert property (@(posedge clk) disable iff (reset)
        (read && waitrequest) |=> (read && $stable(address)))
        else begin
            busErrors++;
            $display("busProtocol: a read was dropped or its address moved under waitrequest");
        end

    writeHeld: assert property (@(posedge clk) disable iff (reset)
        (write && waitrequest) |=> (write && $stable(address) && $stable(writedata)))
        else begin
            busErrors++;
            $display("busProtocol: a write was dropped or changed under waitrequest");
        end

    noOverlap: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            busErrors++;
            $display("busProtocol: read and write were high in the same cycle");
        end

    initial begin
        int start;
        int cycles;
        int snapshot;
        clk = 1'b0;
        reset = 1'b1;
        errors = 0;
        busErrors = 0;
        passed = 0;
        failed = 0;
        transfers = 0;
        storeCount = 0;
        loadSeen = 1'b0;
        dataAddr = signExtend(BaseImm) + signExtend(StoreOffset);
        jumpField = 26'((ResetVector + 32'(JrIndex * 4)) >> 2);
        expectedV0 = computeExpected();
        buildExpectedFetches();
        loadProgram();

        start = errors;
        repeat (16) begin
            @(posedge clk);
            #1;
            checkValue("reset read", 0, read);
            checkValue("reset write", 0, write);
            checkValue("reset active", 1, active);
        end
        reset = 1'b0;
        cycles = 0;
        while (fetchLog.size() == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TimeoutCycles) giveUp("the first fetch");
        end
        checkValue("reset first address", ResetVector, fetchLog[0]);
        checkValue("reset active after start", 1, active);
        finishTest("reset", start);

        start = errors;
        cycles = 0;
        while (!loadSeen) begin
            @(negedge clk);
            cycles++;
            if (cycles > TimeoutCycles) giveUp("the load");
        end
        @(negedge clk);   // Register written at the accepting edge
        checkValue("loadResult registerV0", expectedV0, registerV0);
        finishTest("loadResult", start);

        start = errors;
        cycles = 0;
        while (active) begin
            @(negedge clk);
            cycles++;
            if (cycles > TimeoutCycles) giveUp("active to fall");
        end
        snapshot = transfers;
        repeat (20) begin
            @(negedge clk);
            checkValue("halt active", 0, active);
            checkValue("halt read and write", 0, {read, write});
        end
        checkValue("halt transfers", snapshot, transfers);
        checkValue("halt registerV0", expectedV0, registerV0);
        finishTest("halt", start);

        start = errors;
        checkValue("store count", 1, storeCount);
        checkValue("store address", dataAddr, storeAddress);
        checkValue("store writedata", expectedV0, storeData);
        checkValue("store byteenable", 4'hF, storeEnable);
        finishTest("store", start);

        start = errors;
        checkValue("branchFlow fetch count", expectedFetch.size(), fetchLog.size());
        for (int i = 0; (i < expectedFetch.size()) && (i < fetchLog.size()); i++) begin
            if (fetchLog[i] !== expectedFetch[i]) begin
                checkValue("branchFlow fetch address", expectedFetch[i], fetchLog[i]);
                break;
            end
        end
        finishTest("branchFlow", start);

        start = errors;
        errors = errors + busErrors;
        finishTest("busProtocol", start);

        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule
